/* include/video_cfg.svh */
// constants for the test pattern video core
// raster geometry, square placement, cell size, colours and the bridge map
// included by every module that needs one of these values

`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// raster, 400 clocks by 512 lines with a 320 x 240 window
`define VID_H_TOTAL     10'd400
`define VID_H_BPORCH    10'd10
`define VID_H_ACTIVE    10'd320
`define VID_V_TOTAL     10'd512
`define VID_V_BPORCH    10'd10
`define VID_V_ACTIVE    10'd240
// hs lands a few clocks after vs
`define VID_HS_X        10'd3

// square, centred at start
`define SQ_SIZE         10'd50
`define SQ_INIT_X       10'd135
`define SQ_INIT_Y       10'd95

// 8 pixel checker cells
`define CELL_SHIFT      3
`define RGB_WHITE       24'hFFFFFF
`define RGB_BLACK       24'h000000
`define RGB_MAGENTA     24'hFF00FF
`define RGB_GREEN       24'h00FF00

// bridge map
`define ADDR_SQ_X       32'h00200000
`define ADDR_SQ_Y       32'h00200004
`define ADDR_ANIM       32'h00100000
`define ADDR_DEBUG      32'h00100004
`define ADDR_SCRATCH    32'h00300000
`define ADDR_SQ_RESET   32'h00F00010
`define ADDR_FRAME_CLR  32'h00F00014
`define ADDR_FRAME_STEP 32'h00F00018
`define ADDR_FRAME_CNT  32'h20000000
`define DEBUG_INIT      32'h12005678

`endif

/* design/video_pkg.sv */
// struct types shared by the video core and its testbench
// modules pull these in with a wildcard import in their header

package video_pkg;

    // pixel or line coordinate
    typedef logic [9:0]  coord_t;
    typedef logic [23:0] rgb_t;

    // raster state for the current clock, combinational from the counters
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
        logic   frame_start;
        logic   hs;
    } raster_t;

    // bridge commands, the load and frame fields are one-cycle pulses
    typedef struct packed {
        logic   load_x;
        logic   load_y;
        coord_t new_x;
        coord_t new_y;
        logic   reset_square;
        logic   frame_clear;
        logic   frame_step;
        logic   anim_enable;
    } square_cmd_t;

    // controller key bitmap, msb first so dpad_up sits at bit 0
    typedef struct packed {
        logic face_start, face_select;
        logic trig_r3, trig_l3, trig_r2, trig_l2, trig_r1, trig_l1;
        logic face_y, face_x, face_b, face_a;
        logic dpad_right, dpad_left, dpad_down, dpad_up;
    } pad_keys_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } square_pos_t;

endpackage

/* design/bridge_regs.sv */
// bridge register block for the test pattern core
// decodes writes into stored registers and one-cycle command pulses,
// and muxes read data back out while a read is strobed

`include "video_cfg.svh"

module bridge_regs import video_pkg::*; (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  logic [31:0] bridge_addr,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_wr_data,
    input  logic        bridge_rd,
    output logic [31:0] bridge_rd_data,
    input  square_pos_t square,
    input  logic [15:0] frame_count,
    output square_cmd_t cmd
);

    // square position window is 0x002000xx
    localparam logic [31:0] SQ_BASE = `ADDR_SQ_X;

    logic        sq_window;
    logic        anim_enable;
    logic [31:0] debug_value;
    logic [31:0] scratch_value;
    coord_t      new_x;
    coord_t      new_y;
    logic        load_x;
    logic        load_y;
    logic        reset_square;
    logic        frame_clear;
    logic        frame_step;
    logic [31:0] rd_mux;

    assign sq_window = (bridge_addr[31:8] == SQ_BASE[31:8]);

    //////////////////////////////
    // write decode

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            anim_enable  <= 1'b1;
            debug_value  <= `DEBUG_INIT;
            load_x       <= 1'b0;
            load_y       <= 1'b0;
            reset_square <= 1'b0;
            frame_clear  <= 1'b0;
            frame_step   <= 1'b0;
        end else begin
            // pulses drop after one cycle
            load_x       <= bridge_wr && (bridge_addr == `ADDR_SQ_X);
            load_y       <= bridge_wr && (bridge_addr == `ADDR_SQ_Y);
            reset_square <= bridge_wr && (bridge_addr == `ADDR_SQ_RESET);
            frame_clear  <= bridge_wr && (bridge_addr == `ADDR_FRAME_CLR);
            frame_step   <= bridge_wr && (bridge_addr == `ADDR_FRAME_STEP);
            if (bridge_wr && bridge_addr == `ADDR_ANIM) begin
                anim_enable <= bridge_wr_data[0];
            end
            if (bridge_wr && bridge_addr == `ADDR_DEBUG) begin
                debug_value <= bridge_wr_data;
            end
        end
    end

    // coordinate and scratch payloads, a coordinate keeps the low 10 bits
    always_ff @(posedge clk_74a) begin
        if (bridge_wr && bridge_addr == `ADDR_SQ_X) begin
            new_x <= bridge_wr_data[9:0];
        end
        if (bridge_wr && bridge_addr == `ADDR_SQ_Y) begin
            new_y <= bridge_wr_data[9:0];
        end
        if (bridge_wr && bridge_addr == `ADDR_SCRATCH) begin
            scratch_value <= bridge_wr_data;
        end
    end

    assign cmd.load_x       = load_x;
    assign cmd.load_y       = load_y;
    assign cmd.new_x        = new_x;
    assign cmd.new_y        = new_y;
    assign cmd.reset_square = reset_square;
    assign cmd.frame_clear  = frame_clear;
    assign cmd.frame_step   = frame_step;
    assign cmd.anim_enable  = anim_enable;

    //////////////////////////////
    // read mux

    always_comb begin
        rd_mux = 32'h0;
        if (sq_window) begin
            // only +4 gives y, the rest of the window mirrors x
            rd_mux = (bridge_addr[7:0] == 8'h04) ? {22'h0, square.y} : {22'h0, square.x};
        end else begin
            case (bridge_addr)
                `ADDR_ANIM:      rd_mux = {31'h0, anim_enable};
                `ADDR_DEBUG:     rd_mux = debug_value;
                `ADDR_SCRATCH:   rd_mux = scratch_value;
                `ADDR_FRAME_CNT: rd_mux = {16'h0, frame_count};
                default:         rd_mux = 32'h0;
            endcase
        end
    end

    // bus only sees data while a read is strobed
    assign bridge_rd_data = bridge_rd ? rd_mux : 32'h0;

endmodule

/* design/video_timing.sv */
// raster generator for the 320 x 240 test pattern
// runs the line and frame counters, flags frame start, hs and the window,
// and keeps the frame counter that the bridge reads back

`include "video_cfg.svh"

module video_timing import video_pkg::*; (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  square_cmd_t cmd,
    output raster_t     raster,
    output logic [15:0] frame_count
);

    coord_t x_count;
    coord_t y_count;
    logic   h_active;
    logic   v_active;

    //////////////////////////////
    // line and frame counters

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else if (x_count == `VID_H_TOTAL - 10'd1) begin
            // end of line
            x_count <= '0;
            if (y_count == `VID_V_TOTAL - 10'd1) begin
                y_count <= '0;
            end else begin
                y_count <= y_count + 10'd1;
            end
        end else begin
            x_count <= x_count + 10'd1;
        end
    end

    // active window after the back porch
    assign h_active = (x_count >= `VID_H_BPORCH) && (x_count < `VID_H_BPORCH + `VID_H_ACTIVE);
    assign v_active = (y_count >= `VID_V_BPORCH) && (y_count < `VID_V_BPORCH + `VID_V_ACTIVE);

    // visible coords wrap outside the window, only valid with active
    assign raster.x           = x_count - `VID_H_BPORCH;
    assign raster.y           = y_count - `VID_V_BPORCH;
    assign raster.active      = h_active && v_active;
    assign raster.frame_start = (x_count == '0) && (y_count == '0);
    assign raster.hs          = (x_count == `VID_HS_X);

    //////////////////////////////
    // frame counter
    // clear beats step, step beats the per-frame increment

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            frame_count <= '0;
        end else if (cmd.frame_clear) begin
            frame_count <= '0;
        end else if (cmd.frame_step) begin
            frame_count <= frame_count + 16'd1;
        end else if (raster.frame_start && cmd.anim_enable) begin
            frame_count <= frame_count + 16'd1;
        end
    end

endmodule

/* design/square_ctrl.sv */
// square position for the test pattern
// the d-pad nudges it one pixel per frame inside the active window,
// the bridge can recentre it or load either axis directly

`include "video_cfg.svh"

module square_ctrl import video_pkg::*; (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  raster_t     raster,
    input  pad_keys_t   keys,
    input  square_cmd_t cmd,
    output square_pos_t square
);

    // top-left corner limits keep all 50 pixels on screen
    localparam coord_t X_MAX = `VID_H_ACTIVE - `SQ_SIZE;
    localparam coord_t Y_MAX = `VID_V_ACTIVE - `SQ_SIZE;

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            square.x <= `SQ_INIT_X;
            square.y <= `SQ_INIT_Y;
        end else begin
            // d-pad, sampled once per frame
            if (raster.frame_start) begin
                if (keys.dpad_up && square.y > '0) begin
                    square.y <= square.y - 10'd1;
                end
                // down wins over up when both are held
                if (keys.dpad_down && square.y < Y_MAX) begin
                    square.y <= square.y + 10'd1;
                end
                if (keys.dpad_left && square.x > '0) begin
                    square.x <= square.x - 10'd1;
                end
                if (keys.dpad_right && square.x < X_MAX) begin
                    square.x <= square.x + 10'd1;
                end
            end

            // recentre overrides movement
            if (cmd.reset_square) begin
                square.x <= `SQ_INIT_X;
                square.y <= `SQ_INIT_Y;
            end

            // direct loads win per axis
            if (cmd.load_x) begin
                square.x <= cmd.new_x;
            end
            if (cmd.load_y) begin
                square.y <= cmd.new_y;
            end
        end
    end

endmodule

/* design/pixel_compose.sv */
// pixel colour for the test pattern
// square interior in the key colour over an 8 pixel checkerboard,
// black outside the window; every video output is registered here

`include "video_cfg.svh"

module pixel_compose import video_pkg::*; (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  raster_t     raster,
    input  square_pos_t square,
    input  pad_keys_t   keys,
    output rgb_t        video_rgb,
    output logic        video_de,
    output logic        video_vs,
    output logic        video_hs
);

    logic in_square;
    logic cell_odd;
    rgb_t pixel_rgb;

    // inner 48 x 48, the one pixel ring shows the background
    assign in_square = (raster.x > square.x) && (raster.x < square.x + `SQ_SIZE - 10'd1)
                    && (raster.y > square.y) && (raster.y < square.y + `SQ_SIZE - 10'd1);

    // cell column plus cell row parity is just the xor of their lsbs
    assign cell_odd = raster.x[`CELL_SHIFT] ^ raster.y[`CELL_SHIFT];

    always_comb begin
        if (!raster.active) begin
            pixel_rgb = `RGB_BLACK;
        end else if (in_square) begin
            // face_a has priority over face_b
            if (keys.face_a) begin
                pixel_rgb = `RGB_MAGENTA;
            end else if (keys.face_b) begin
                pixel_rgb = `RGB_GREEN;
            end else begin
                pixel_rgb = `RGB_WHITE;
            end
        end else begin
            pixel_rgb = cell_odd ? `RGB_WHITE : `RGB_BLACK;
        end
    end

    //////////////////////////////
    // output stage, one clock behind the raster

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= `RGB_BLACK;
            video_de  <= 1'b0;
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
        end else begin
            video_rgb <= pixel_rgb;
            video_de  <= raster.active;
            video_vs  <= raster.frame_start;
            video_hs  <= raster.hs;
        end
    end

endmodule

/* design/pocket_square_top.sv */
// top of the test pattern video core
// wires the bridge registers, raster timing, square control and pixel stage

module pocket_square_top import video_pkg::*; (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  logic [31:0] bridge_addr,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_wr_data,
    input  logic        bridge_rd,
    output logic [31:0] bridge_rd_data,
    input  pad_keys_t   cont1_key,
    output rgb_t        video_rgb,
    output logic        video_de,
    output logic        video_vs,
    output logic        video_hs
);

    // bridge commands out, live state back for readback
    square_cmd_t cmd;
    square_pos_t square;
    raster_t     raster;
    logic [15:0] frame_count;

    bridge_regs bridge_regs_inst (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .square         (square),
        .frame_count    (frame_count),
        .cmd            (cmd)
    );

    video_timing video_timing_inst (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .cmd         (cmd),
        .raster      (raster),
        .frame_count (frame_count)
    );

    square_ctrl square_ctrl_inst (
        .clk_74a (clk_74a),
        .reset_n (reset_n),
        .raster  (raster),
        .keys    (cont1_key),
        .cmd     (cmd),
        .square  (square)
    );

    pixel_compose pixel_compose_inst (
        .clk_74a   (clk_74a),
        .reset_n   (reset_n),
        .raster    (raster),
        .square    (square),
        .keys      (cont1_key),
        .video_rgb (video_rgb),
        .video_de  (video_de),
        .video_vs  (video_vs),
        .video_hs  (video_hs)
    );

endmodule

/* verification/tb_pocket_square.sv */
// testbench for the test pattern video core
// steps through the stimulus file, drives the bridge and pad on the falling edge,
// and checks registers, raster timing, square motion, frame count and pixels

`include "video_cfg.svh"

module tb_pocket_square import video_pkg::*; ();

    localparam int    CLK_PERIOD   = 100;
    localparam int    H_TOTAL      = int'(`VID_H_TOTAL);
    localparam int    H_BPORCH     = int'(`VID_H_BPORCH);
    localparam int    H_ACTIVE     = int'(`VID_H_ACTIVE);
    localparam int    V_BPORCH     = int'(`VID_V_BPORCH);
    localparam int    V_ACTIVE     = int'(`VID_V_ACTIVE);
    localparam int    FRAME_CYCLES = H_TOTAL * int'(`VID_V_TOTAL);
    localparam string STIM_FILE    = "verification/pocket_square_stimulus.txt";

    logic        clk_74a;
    logic        reset_n;
    logic [31:0] bridge_addr;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic        bridge_rd;
    logic [31:0] bridge_rd_data;
    pad_keys_t   cont1_key;
    rgb_t        video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;

    logic [31:0] rng_state = 32'd60729;
    bit          watchdog_armed = 1'b0;
    longint      watchdog_limit;

    pocket_square_top pocket_square_top_inst (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .cont1_key      (cont1_key),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_vs       (video_vs),
        .video_hs       (video_hs)
    );

    initial begin
        clk_74a = 1'b0;
        forever #(CLK_PERIOD / 2) clk_74a = ~clk_74a;
    end

    //////////////////////////////
    // failure reporting and checks

    task automatic abort_run(input string reason);
        $display("Test failures found");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            abort_run("read data mismatch");
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected 0x%06h actual 0x%06h", name, expected, actual);
            abort_run("pixel colour mismatch");
        end
    endtask

    task automatic check_pos(input string name, input square_pos_t expected,
                             input square_pos_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected (%0d,%0d) actual (%0d,%0d)", name,
                     expected.x, expected.y, actual.x, actual.y);
            abort_run("square position mismatch");
        end
    endtask

    // 32 bit xorshift that picks the sampled pixels
    function automatic logic [31:0] xorshift32(input logic [31:0] seed);
        logic [31:0] v;
        v = seed;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // reference colour straight from the pattern rules
    function automatic rgb_t expected_pixel(input int px, input int py, input pad_keys_t keys,
                                            input square_pos_t sq);
        int   dx;
        int   dy;
        int   inner;
        logic in_inner;
        dx = px - int'(sq.x);
        dy = py - int'(sq.y);
        inner = int'(`SQ_SIZE) - 2;
        // inner 48 x 48 sits one pixel in from each edge
        in_inner = (dx >= 1) && (dx <= inner) && (dy >= 1) && (dy <= inner);
        if (in_inner) begin
            if (keys.face_a) begin
                return `RGB_MAGENTA;
            end else if (keys.face_b) begin
                return `RGB_GREEN;
            end
            return `RGB_WHITE;
        end
        // odd cell column plus cell row is white
        if ((((px >> `CELL_SHIFT) + (py >> `CELL_SHIFT)) % 2) == 1) begin
            return `RGB_WHITE;
        end
        return `RGB_BLACK;
    endfunction

    //////////////////////////////
    // bus and frame helpers all entered on a falling edge

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
        // pulse plus its effect land within two edges
        @(negedge clk_74a);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        // combinational read data sampled mid low phase
        #(CLK_PERIOD / 4);
        data = bridge_rd_data;
        @(negedge clk_74a);
        bridge_rd = 1'b0;
    endtask

    task automatic read_square(output square_pos_t pos);
        logic [31:0] data;
        bus_read(`ADDR_SQ_X, data);
        pos.x = data[9:0];
        bus_read(`ADDR_SQ_Y, data);
        pos.y = data[9:0];
    endtask

    // returns on the falling edge where the last vs is seen
    task automatic wait_frames(input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            @(negedge clk_74a);
            if (video_vs) begin
                seen++;
            end
        end
    endtask

    task automatic check_raster(input logic [31:0] de_len, input logic [31:0] de_lines,
                                input logic [31:0] hs_total);
        int de_run;
        int lines;
        int vs_count;
        int hs_count;
        de_run = 0;
        lines = 0;
        vs_count = 0;
        hs_count = 0;
        wait_frames(1);
        // exactly one frame starting on the vs cycle
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0) begin
                @(negedge clk_74a);
            end
            if (video_vs) begin
                vs_count++;
            end
            if (video_hs) begin
                hs_count++;
            end
            if (video_de) begin
                de_run++;
            end else if (de_run != 0) begin
                check_word("de run length", de_len, de_run);
                lines++;
                de_run = 0;
            end
        end
        check_word("lines with de", de_lines, lines);
        check_word("vs pulses per frame", 32'd1, vs_count);
        check_word("hs pulses per frame", hs_total, hs_count);
    endtask

    task automatic check_pixels(input pad_keys_t keys, input square_pos_t sq);
        int   hc;
        int   vc;
        int   px;
        int   py;
        int   samples;
        rgb_t want;
        cont1_key = keys;
        wait_frames(1);
        // output at the vs cycle belongs to counter position 0,0
        hc = 0;
        vc = 0;
        samples = 0;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0) begin
                @(negedge clk_74a);
                if (hc == H_TOTAL - 1) begin
                    hc = 0;
                    vc++;
                end else begin
                    hc++;
                end
            end
            px = hc - H_BPORCH;
            py = vc - V_BPORCH;
            if (px >= 0 && px < H_ACTIVE && py >= 0 && py < V_ACTIVE) begin
                rng_state = xorshift32(rng_state);
                // about one active pixel in 64
                if (rng_state[5:0] == 6'd0) begin
                    want = expected_pixel(px, py, keys, sq);
                    check_rgb($sformatf("pixel (%0d,%0d)", px, py), want, video_rgb);
                    samples++;
                end
            end
        end
        cont1_key = '0;
        if (samples == 0) begin
            abort_run("no active pixel was sampled in the frame");
        end
    endtask

    //////////////////////////////
    // stimulus file counted once for the watchdog and then run

    task automatic process_stimulus(input bit execute, inout longint frames);
        int          fd;
        int          got;
        int          fields;
        int          line_no;
        string       line;
        string       op;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] data;
        square_pos_t pos;
        square_pos_t want;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            op = "";
            a = '0;
            b = '0;
            c = '0;
            fields = 0;
            got = $fgets(line, fd);
            line_no++;
            if (got > 0) begin
                fields = $sscanf(line, "%s %h %h %h", op, a, b, c);
            end
            // comment lines start with a hash
            if (fields >= 1 && op.getc(0) != 8'h23) begin
                name = $sformatf("line %0d %s 0x%08h", line_no, op, a);
                if (!execute) begin
                    if (op == "keys") begin
                        frames += longint'(b) + 1;
                    end else if (op == "frames") begin
                        frames += longint'(a) + 1;
                    end else if (op == "raster" || op == "pix") begin
                        frames += 2;
                    end
                end else if (op == "wr") begin
                    bus_write(a, b);
                end else if (op == "rd") begin
                    bus_read(a, data);
                    check_word(name, b, data);
                end else if (op == "pos") begin
                    want.x = a[9:0];
                    want.y = b[9:0];
                    read_square(pos);
                    check_pos(name, want, pos);
                end else if (op == "keys") begin
                    cont1_key = a[15:0];
                    wait_frames(b);
                    cont1_key = '0;
                end else if (op == "frames") begin
                    wait_frames(a);
                end else if (op == "raster") begin
                    check_raster(a, b, c);
                end else if (op == "pix") begin
                    want.x = b[9:0];
                    want.y = c[9:0];
                    check_pixels(a[15:0], want);
                end else begin
                    abort_run($sformatf("unknown operation on stimulus line %0d", line_no));
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        longint frames;
        reset_n        = 1'b0;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        bridge_rd      = 1'b0;
        cont1_key      = '0;
        frames         = 0;
        process_stimulus(1'b0, frames);
        watchdog_limit = (frames + 2) * FRAME_CYCLES * CLK_PERIOD;
        watchdog_armed = 1'b1;
        repeat (5) @(negedge clk_74a);
        reset_n = 1'b1;
        @(negedge clk_74a);
        process_stimulus(1'b1, frames);
        $display("All tests passed!");
        $finish;
    end

    // budget covers every frame the file waits on plus two spare
    initial begin
        wait (watchdog_armed);
        #(watchdog_limit);
        abort_run("watchdog expired before the stimulus file was finished");
    end

endmodule

/* pocket_square.f */
+incdir+include
design/video_pkg.sv
design/bridge_regs.sv
design/video_timing.sv
design/square_ctrl.sv
design/pixel_compose.sv
design/pocket_square_top.sv
verification/tb_pocket_square.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator and run it, exit status carries the verdict
cd "$(dirname "$0")" \
    && verilator --binary --timing -j 0 \
        --top-module tb_pocket_square \
        -f pocket_square.f \
        -o tb_pocket_square_sim \
    && ./obj_dir/tb_pocket_square_sim \
    && echo "simulation finished cleanly" \
    || { echo "simulation build or run did not succeed"; exit 1; }

/* verification/pocket_square_stimulus.txt */
# op a b c in hex: wr addr data, rd addr expect, pos x y, keys bits frames, frames n
# raster de_len de_lines hs_count, pix keys square_x square_y
pos 87 5f
rd 00100004 12005678
rd 00100000 1
rd 00200008 87
wr 00300000 a5a51234
rd 00300000 a5a51234
wr 00100004 cafe0001
rd 00100004 cafe0001
rd 00400000 0
raster 140 f0 200
keys a 3
pos 8a 62
wr 00200000 2
keys 4 5
pos 0 62
wr 00200004 10
wr 00200000 64
pos 64 10
wr 00F00010 0
pos 87 5f
pix 10 87 5f
pix 20 87 5f
pix 0 87 5f
wr 00F00014 0
frames 3
rd 20000000 3
wr 00100000 0
wr 00F00014 0
wr 00F00018 0
rd 20000000 1
frames 1
rd 20000000 1
rd 00100000 0
